// ==== axi_cfg_pkg.sv ====
/*
  Bridge widths and depths. DATA_W must be a multiple of 8, and every
  beat is full width. ID_FIFO_DEPTH limits the outstanding beats per direction.
*/
package axi_cfg_pkg;

  // Address and data bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Transaction ID width
  localparam int unsigned ID_W = 4;

  // AXI4 burst length field, holds beats minus one
  localparam int unsigned LEN_W = 8;

  // Register file size in words
  localparam int unsigned REG_WORDS = 16;

  // Outstanding IDs held per direction in the reflect stage
  localparam int unsigned ID_FIFO_DEPTH = 4;

endpackage

// ==== axi_types_pkg.sv ====
/*
  Bus payload types and response codes, sized from the config package.
  Only OKAY and SLVERR are ever produced.
*/
package axi_types_pkg;

  import axi_cfg_pkg::*;

  // Payload vectors
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;
  typedef logic [ID_W-1:0]     id_t;
  typedef logic [LEN_W-1:0]    len_t;
  typedef logic [1:0]          resp_t;

  // Response codes, ordered so a larger code is the worse one
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // Splitter write FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Splitter read FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

endpackage

// ==== axi_beat_if.sv ====
/*
  Single-beat full AXI with IDs. No len or last fields, since every
  transfer on this bus is exactly one beat.
*/
interface axi_beat_if;

  import axi_types_pkg::*;

  // Write address
  logic  aw_valid;
  logic  aw_ready;
  id_t   aw_id;
  addr_t aw_addr;
  // Write data
  logic  w_valid;
  logic  w_ready;
  data_t w_data;
  strb_t w_strb;
  // Write response
  logic  b_valid;
  logic  b_ready;
  id_t   b_id;
  resp_t b_resp;
  // Read address
  logic  ar_valid;
  logic  ar_ready;
  id_t   ar_id;
  addr_t ar_addr;
  // Read data
  logic  r_valid;
  logic  r_ready;
  id_t   r_id;
  data_t r_data;
  resp_t r_resp;

  modport mgr (
    output aw_valid, aw_id, aw_addr, w_valid, w_data, w_strb, b_ready,
    output ar_valid, ar_id, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_id, b_resp, ar_ready,
    input  r_valid, r_id, r_data, r_resp
  );

  modport sub (
    input  aw_valid, aw_id, aw_addr, w_valid, w_data, w_strb, b_ready,
    input  ar_valid, ar_id, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_id, b_resp, ar_ready,
    output r_valid, r_id, r_data, r_resp
  );

endinterface

// ==== axi_lite_if.sv ====
/*
  AXI4-Lite without PROT. Channels and handshakes as in AXI4, without
  IDs, bursts or last.
*/
interface axi_lite_if;

  import axi_types_pkg::*;

  // Write address
  logic  aw_valid;
  logic  aw_ready;
  addr_t aw_addr;
  // Write data
  logic  w_valid;
  logic  w_ready;
  data_t w_data;
  strb_t w_strb;
  // Write response
  logic  b_valid;
  logic  b_ready;
  resp_t b_resp;
  // Read address
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  // Read data
  logic  r_valid;
  logic  r_ready;
  data_t r_data;
  resp_t r_resp;

  modport mgr (
    output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    output ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready,
    input  r_valid, r_data, r_resp
  );

  modport sub (
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    input  ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready,
    output r_valid, r_data, r_resp
  );

endinterface

// ==== id_fifo.sv ====
/*
  Fall-through ID FIFO. Head shows on data_o while not empty. Push when
  full and pop when empty are ignored.
*/
module id_fifo (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  axi_types_pkg::id_t  data_i,
  input  logic                pop_i,
  output axi_types_pkg::id_t  data_o,
  output logic                full_o,
  output logic                empty_o
);

  import axi_cfg_pkg::*;
  import axi_types_pkg::*;

  localparam int unsigned PTR_W = (ID_FIFO_DEPTH > 1) ? $clog2(ID_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(ID_FIFO_DEPTH + 1);

  id_t              mem_q [ID_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(ID_FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  // Head falls through, valid only while not empty
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at the depth, count tracks occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ID_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ID_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== axi_burst_splitter.sv ====
/*
  INCR bursts only, every beat full width. One write and one read burst
  at a time; beat count comes from len, so w_last_i is not checked.
*/
module axi_burst_splitter (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Upstream write address
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_types_pkg::id_t    aw_id_i,
  input  axi_types_pkg::addr_t  aw_addr_i,
  input  axi_types_pkg::len_t   aw_len_i,
  // Upstream write data
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  axi_types_pkg::data_t  w_data_i,
  input  axi_types_pkg::strb_t  w_strb_i,
  input  logic                  w_last_i,
  // Upstream write response
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output axi_types_pkg::id_t    b_id_o,
  output axi_types_pkg::resp_t  b_resp_o,
  // Upstream read address
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  axi_types_pkg::id_t    ar_id_i,
  input  axi_types_pkg::addr_t  ar_addr_i,
  input  axi_types_pkg::len_t   ar_len_i,
  // Upstream read data
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output axi_types_pkg::id_t    r_id_o,
  output axi_types_pkg::data_t  r_data_o,
  output axi_types_pkg::resp_t  r_resp_o,
  output logic                  r_last_o,
  // Single-beat side
  axi_beat_if.mgr               beat_o
);

  import axi_cfg_pkg::*;
  import axi_types_pkg::*;

  // Write side
  wr_state_e        wr_state_q;
  id_t              wr_id_q;
  id_t              b_id_q;
  addr_t            wr_addr_q;
  len_t             wr_len_q;
  resp_t            wr_resp_q;
  // One extra bit so the W count can pass the last beat
  logic [LEN_W:0]   aw_cnt_q;
  logic [LEN_W:0]   w_cnt_q;
  len_t             b_cnt_q;
  logic             wr_busy;
  logic             w_allow;
  // Read side
  rd_state_e        rd_state_q;
  id_t              rd_id_q;
  addr_t            rd_addr_q;
  len_t             rd_len_q;
  len_t             ar_cnt_q;
  len_t             r_cnt_q;
  logic             rd_busy;

  assign wr_busy = (wr_state_q == WR_ADDR) || (wr_state_q == WR_DATA);
  // W beat k may go once AW beat k is on the bus
  assign w_allow = wr_busy && (w_cnt_q <= aw_cnt_q) && (w_cnt_q <= {1'b0, wr_len_q});

  assign aw_ready_o      = (wr_state_q == WR_IDLE);
  assign beat_o.aw_valid = (wr_state_q == WR_ADDR);
  assign beat_o.aw_id    = wr_id_q;
  assign beat_o.aw_addr  = wr_addr_q;
  // W passes straight through, gated by beat position
  assign beat_o.w_valid  = w_valid_i & w_allow;
  assign beat_o.w_data   = w_data_i;
  assign beat_o.w_strb   = w_strb_i;
  assign w_ready_o       = beat_o.w_ready & w_allow;
  // Beat responses are absorbed and merged here
  assign beat_o.b_ready  = wr_busy;
  assign b_valid_o       = (wr_state_q == WR_RESP);
  assign b_id_o          = b_id_q;
  assign b_resp_o        = wr_resp_q;

  // Write burst payload, address steps one word per issued beat
  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      wr_id_q   <= aw_id_i;
      wr_addr_q <= aw_addr_i;
      wr_len_q  <= aw_len_i;
    end else if (beat_o.aw_valid && beat_o.aw_ready) begin
      wr_addr_q <= wr_addr_q + addr_t'(DATA_W / 8);
    end
    // Outer B carries the ID reflected on the beat responses
    if (beat_o.b_valid && beat_o.b_ready) begin
      b_id_q <= beat_o.b_id;
    end
  end

  // Write FSM with independent issue, data and response counters
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_state_q <= WR_IDLE;
      aw_cnt_q   <= '0;
      w_cnt_q    <= '0;
      b_cnt_q    <= '0;
      wr_resp_q  <= RESP_OKAY;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (aw_valid_i) begin
            wr_state_q <= WR_ADDR;
            aw_cnt_q   <= '0;
            w_cnt_q    <= '0;
            b_cnt_q    <= '0;
            wr_resp_q  <= RESP_OKAY;
          end
        end
        WR_RESP: begin
          if (b_ready_i) begin
            wr_state_q <= WR_IDLE;
          end
        end
        default: begin
          if (beat_o.aw_valid && beat_o.aw_ready) begin
            aw_cnt_q <= aw_cnt_q + 1'b1;
            if (aw_cnt_q == {1'b0, wr_len_q}) begin
              wr_state_q <= WR_DATA;
            end
          end
          if (beat_o.w_valid && beat_o.w_ready) begin
            w_cnt_q <= w_cnt_q + 1'b1;
          end
          // Worst response wins, SLVERR over OKAY
          if (beat_o.b_valid) begin
            if (beat_o.b_resp > wr_resp_q) begin
              wr_resp_q <= beat_o.b_resp;
            end
            b_cnt_q <= b_cnt_q + 1'b1;
            // Last beat B only comes after the last AW
            if (b_cnt_q == wr_len_q) begin
              wr_state_q <= WR_RESP;
            end
          end
        end
      endcase
    end
  end

  assign rd_busy         = (rd_state_q != RD_IDLE);
  assign ar_ready_o      = ~rd_busy;
  assign beat_o.ar_valid = (rd_state_q == RD_ADDR);
  assign beat_o.ar_id    = rd_id_q;
  assign beat_o.ar_addr  = rd_addr_q;
  // R beats pass through with their own response
  assign beat_o.r_ready  = r_ready_i & rd_busy;
  assign r_valid_o       = beat_o.r_valid & rd_busy;
  assign r_id_o          = beat_o.r_id;
  assign r_data_o        = beat_o.r_data;
  assign r_resp_o        = beat_o.r_resp;
  assign r_last_o        = (r_cnt_q == rd_len_q);

  // Read burst payload
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      rd_id_q   <= ar_id_i;
      rd_addr_q <= ar_addr_i;
      rd_len_q  <= ar_len_i;
    end else if (beat_o.ar_valid && beat_o.ar_ready) begin
      rd_addr_q <= rd_addr_q + addr_t'(DATA_W / 8);
    end
  end

  // Read FSM, burst ends on the counted last R
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state_q <= RD_IDLE;
      ar_cnt_q   <= '0;
      r_cnt_q    <= '0;
    end else if (rd_state_q == RD_IDLE) begin
      if (ar_valid_i) begin
        rd_state_q <= RD_ADDR;
        ar_cnt_q   <= '0;
        r_cnt_q    <= '0;
      end
    end else begin
      if (beat_o.ar_valid && beat_o.ar_ready) begin
        ar_cnt_q <= ar_cnt_q + 1'b1;
        if (ar_cnt_q == rd_len_q) begin
          rd_state_q <= RD_DATA;
        end
      end
      if (r_valid_o && r_ready_i) begin
        r_cnt_q <= r_cnt_q + 1'b1;
        if (r_last_o) begin
          rd_state_q <= RD_IDLE;
        end
      end
    end
  end

endmodule

// ==== axi_id_reflect.sv ====
/*
  Single-beat AXI to AXI4-Lite. Expects one beat per AW and AR, and a
  subordinate that answers in order. No added latency.
*/
module axi_id_reflect (
  input  logic     clk_i,
  input  logic     arst_n_i,
  axi_beat_if.sub  beat_i,
  axi_lite_if.mgr  lite_o
);

  import axi_types_pkg::*;

  logic aw_full;
  logic aw_empty;
  logic aw_push;
  logic aw_pop;
  logic ar_full;
  logic ar_empty;
  logic ar_push;
  logic ar_pop;
  id_t  aw_head_id;
  id_t  ar_head_id;

  // Write address, held off while the ID store is full
  assign lite_o.aw_valid = beat_i.aw_valid & ~aw_full;
  assign lite_o.aw_addr  = beat_i.aw_addr;
  assign beat_i.aw_ready = lite_o.aw_ready & ~aw_full;
  // Write data passes unchanged
  assign lite_o.w_valid  = beat_i.w_valid;
  assign lite_o.w_data   = beat_i.w_data;
  assign lite_o.w_strb   = beat_i.w_strb;
  assign beat_i.w_ready  = lite_o.w_ready;
  // Write response carries the oldest stored ID
  assign beat_i.b_valid  = lite_o.b_valid & ~aw_empty;
  assign beat_i.b_id     = aw_head_id;
  assign beat_i.b_resp   = lite_o.b_resp;
  assign lite_o.b_ready  = beat_i.b_ready & ~aw_empty;

  assign aw_push = beat_i.aw_valid & beat_i.aw_ready;
  assign aw_pop  = beat_i.b_valid & beat_i.b_ready;

  id_fifo i_aw_id_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (aw_push),
    .data_i   (beat_i.aw_id),
    .pop_i    (aw_pop),
    .data_o   (aw_head_id),
    .full_o   (aw_full),
    .empty_o  (aw_empty)
  );

  // Read address and data, same scheme as the write side
  assign lite_o.ar_valid = beat_i.ar_valid & ~ar_full;
  assign lite_o.ar_addr  = beat_i.ar_addr;
  assign beat_i.ar_ready = lite_o.ar_ready & ~ar_full;
  assign beat_i.r_valid  = lite_o.r_valid & ~ar_empty;
  assign beat_i.r_id     = ar_head_id;
  assign beat_i.r_data   = lite_o.r_data;
  assign beat_i.r_resp   = lite_o.r_resp;
  assign lite_o.r_ready  = beat_i.r_ready & ~ar_empty;

  assign ar_push = beat_i.ar_valid & beat_i.ar_ready;
  assign ar_pop  = beat_i.r_valid & beat_i.r_ready;

  id_fifo i_ar_id_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (ar_push),
    .data_i   (beat_i.ar_id),
    .pop_i    (ar_pop),
    .data_o   (ar_head_id),
    .full_o   (ar_full),
    .empty_o  (ar_empty)
  );

endmodule

// ==== lite_reg_file.sv ====
/*
  AXI4-Lite register file of REG_WORDS words from address 0. Addresses
  beyond the last word give SLVERR, write nothing and read zero.
*/
module lite_reg_file (
  input  logic     clk_i,
  input  logic     arst_n_i,
  axi_lite_if.sub  lite_i
);

  import axi_cfg_pkg::*;
  import axi_types_pkg::*;

  localparam int unsigned IDX_W = $clog2(REG_WORDS);

  data_t            regs_q [REG_WORDS];
  logic             b_valid_q;
  resp_t            b_resp_q;
  logic             r_valid_q;
  resp_t            r_resp_q;
  data_t            r_data_q;
  logic             wr_fire;
  logic             rd_fire;
  logic             wr_hit;
  logic             rd_hit;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  // AW and W are taken together, only with no B pending
  assign wr_fire = lite_i.aw_valid & lite_i.w_valid & ~b_valid_q;
  assign lite_i.aw_ready = wr_fire;
  assign lite_i.w_ready  = wr_fire;
  assign rd_fire = lite_i.ar_valid & ~r_valid_q;
  assign lite_i.ar_ready = ~r_valid_q;

  // Word decode
  assign wr_hit = (lite_i.aw_addr < addr_t'(REG_WORDS * 4));
  assign rd_hit = (lite_i.ar_addr < addr_t'(REG_WORDS * 4));
  assign wr_idx = lite_i.aw_addr[IDX_W+1:2];
  assign rd_idx = lite_i.ar_addr[IDX_W+1:2];

  assign lite_i.b_valid = b_valid_q;
  assign lite_i.b_resp  = b_resp_q;
  assign lite_i.r_valid = r_valid_q;
  assign lite_i.r_resp  = r_resp_q;
  assign lite_i.r_data  = r_data_q;

  // Registers, byte lanes written per strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_fire && wr_hit) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (lite_i.w_strb[b]) begin
          regs_q[wr_idx][8*b +: 8] <= lite_i.w_data[8*b +: 8];
        end
      end
    end
  end

  // Response valids hold until accepted
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      b_resp_q  <= RESP_OKAY;
      r_valid_q <= 1'b0;
      r_resp_q  <= RESP_OKAY;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (lite_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (lite_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Read data, zero on a decode miss
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= rd_hit ? regs_q[rd_idx] : '0;
    end
  end

endmodule

// ==== axi_lite_bridge_top.sv ====
/*
  Full AXI4 INCR bursts in, 16-word AXI4-Lite register file behind.
  No FIXED or WRAP bursts, narrow beats or atomics.
*/
module axi_lite_bridge_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_types_pkg::id_t    aw_id_i,
  input  axi_types_pkg::addr_t  aw_addr_i,
  input  axi_types_pkg::len_t   aw_len_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  axi_types_pkg::data_t  w_data_i,
  input  axi_types_pkg::strb_t  w_strb_i,
  input  logic                  w_last_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output axi_types_pkg::id_t    b_id_o,
  output axi_types_pkg::resp_t  b_resp_o,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  axi_types_pkg::id_t    ar_id_i,
  input  axi_types_pkg::addr_t  ar_addr_i,
  input  axi_types_pkg::len_t   ar_len_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output axi_types_pkg::id_t    r_id_o,
  output axi_types_pkg::data_t  r_data_o,
  output axi_types_pkg::resp_t  r_resp_o,
  output logic                  r_last_o
);

  // Splitter to reflect, then reflect to register file
  axi_beat_if beat ();
  axi_lite_if lite ();

  axi_burst_splitter i_axi_burst_splitter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .aw_len_i   (aw_len_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .ar_len_i   (ar_len_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_id_o     (r_id_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .beat_o     (beat.mgr)
  );

  axi_id_reflect i_axi_id_reflect (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .beat_i   (beat.sub),
    .lite_o   (lite.mgr)
  );

  lite_reg_file i_lite_reg_file (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .lite_i   (lite.sub)
  );

endmodule

// ==== tb_axi_lite_bridge.sv ====
/*
  Reads test_input.txt from the project root and runs one transaction at a time.
  Read data and beat responses are predicted from a shadow copy of the registers.
*/
module tb_axi_lite_bridge;

  import axi_cfg_pkg::*;
  import axi_types_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'h596f;
  localparam int unsigned IDX_W     = $clog2(REG_WORDS);

  // DUT ports
  logic  clk_i = 1'b0;
  logic  arst_n_i;
  logic  aw_valid_i, aw_ready_o;
  id_t   aw_id_i;
  addr_t aw_addr_i;
  len_t  aw_len_i;
  logic  w_valid_i, w_ready_o, w_last_i;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  b_valid_o, b_ready_i;
  id_t   b_id_o;
  resp_t b_resp_o;
  logic  ar_valid_i, ar_ready_o;
  id_t   ar_id_i;
  addr_t ar_addr_i;
  len_t  ar_len_i;
  logic  r_valid_o, r_ready_i, r_last_o;
  id_t   r_id_o;
  data_t r_data_o;
  resp_t r_resp_o;

  // Transaction list, one entry per file line
  logic [7:0] op_q[$];
  id_t        id_q[$];
  addr_t      addr_q[$];
  len_t       len_q[$];
  strb_t      strb_q[$];
  resp_t      resp_q[$];

  data_t       shadow [REG_WORDS];
  logic [31:0] data_lfsr;
  logic [31:0] rdy_lfsr;
  int          cycles = 0;
  int          cycle_limit = 1000;
  int          b_seen = 0;
  int          r_seen = 0;
  int          resp_errs = 0;
  int          id_errs = 0;
  int          data_errs = 0;
  int          last_errs = 0;
  int          other_errs = 0;

  axi_lite_bridge_top i_axi_lite_bridge_top (.*);

  always #5 clk_i = ~clk_i;

  // Right-shift Galois LFSR, one step
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic draw_word(output data_t w);
    for (int i = 0; i < DATA_W; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      w[i]      = data_lfsr[0];
    end
  endtask

  // Shared back-pressure bit for B and R, new each cycle
  initial begin
    rdy_lfsr  = LFSR_SEED;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      rdy_lfsr  = lfsr_next(rdy_lfsr);
      b_ready_i = rdy_lfsr[0];
      r_ready_i = rdy_lfsr[0];
    end
  end

  // Transfers seen before the edge that takes them
  always @(negedge clk_i) begin
    if (b_valid_o && b_ready_i) begin
      b_seen++;
    end
    if (r_valid_o && r_ready_i) begin
      r_seen++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      id_errs++;
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      last_errs++;
    end
  endtask

  task automatic print_counts();
    $display("Errors: resp %0d, id %0d, data %0d, last %0d, other %0d",
             resp_errs, id_errs, data_errs, last_errs, other_errs);
  endtask

  task automatic load_transactions();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] f_id, f_addr, f_len, f_strb, f_resp;
    fd = $fopen("test_input.txt", "r");
    if (fd == 0) begin
      $display("Error: test_input.txt could not be opened");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        op = line.getc(0);
        n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                     f_id, f_addr, f_len, f_strb, f_resp);
        if (n == 5 && (op == "W" || op == "R")) begin
          op_q.push_back(op);
          id_q.push_back(id_t'(f_id));
          addr_q.push_back(addr_t'(f_addr));
          len_q.push_back(len_t'(f_len));
          strb_q.push_back(strb_t'(f_strb));
          resp_q.push_back(resp_t'(f_resp));
        end else begin
          $display("Error: test_input.txt has a line that does not parse: %s", line);
          other_errs++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic do_write(input id_t id, input addr_t base, input len_t len,
                          input strb_t strb, input resp_t exp_resp);
    addr_t            a;
    data_t            d;
    logic [IDX_W-1:0] idx;
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = base;
    aw_len_i   = len;
    do @(negedge clk_i); while (!aw_ready_o);
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      draw_word(d);
      a         = base + addr_t'((DATA_W / 8) * i);
      idx       = a[IDX_W+1:2];
      w_valid_i = 1'b1;
      w_data_i  = d;
      w_strb_i  = strb;
      w_last_i  = (i == int'(len));
      do @(negedge clk_i); while (!w_ready_o);
      @(posedge clk_i);
      #1;
      // Only in-range words take the enabled byte lanes
      if (a < addr_t'(REG_WORDS * 4)) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (strb[b]) begin
            shadow[idx][8*b +: 8] = d[8*b +: 8];
          end
        end
      end
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    do @(negedge clk_i); while (!(b_valid_o && b_ready_i));
    check_id("b_id_o", b_id_o, id);
    check_resp("b_resp_o", b_resp_o, exp_resp);
    @(posedge clk_i);
    #1;
  endtask

  task automatic do_read(input id_t id, input addr_t base, input len_t len,
                         input resp_t exp_resp);
    addr_t            a;
    logic             hit;
    logic [IDX_W-1:0] idx;
    resp_t            worst;
    worst = RESP_OKAY;
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = base;
    ar_len_i   = len;
    do @(negedge clk_i); while (!ar_ready_o);
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      a   = base + addr_t'((DATA_W / 8) * i);
      idx = a[IDX_W+1:2];
      hit = (a < addr_t'(REG_WORDS * 4));
      do @(negedge clk_i); while (!(r_valid_o && r_ready_i));
      check_id("r_id_o", r_id_o, id);
      check_resp("r_resp_o", r_resp_o, hit ? RESP_OKAY : RESP_SLVERR);
      check_data("r_data_o", r_data_o, hit ? shadow[idx] : '0);
      check_last("r_last_o", r_last_o, i == int'(len));
      if (r_resp_o > worst) begin
        worst = r_resp_o;
      end
      @(posedge clk_i);
      #1;
    end
    // Worst beat code against the file
    check_resp("r_resp_o of burst", worst, exp_resp);
  endtask

  initial begin
    int beats;
    int b_want;
    int r_want;
    arst_n_i   = 1'b0;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    data_lfsr  = LFSR_SEED;
    for (int i = 0; i < REG_WORDS; i++) begin
      shadow[i] = '0;
    end
    load_transactions();
    beats  = 0;
    b_want = 0;
    r_want = 0;
    foreach (len_q[i]) begin
      beats += int'(len_q[i]) + 1;
    end
    cycle_limit = 200 * beats;
    if (op_q.size() == 0) begin
      $display("Error: no transactions were loaded");
      other_errs++;
    end else begin
      repeat (8) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      foreach (op_q[i]) begin
        if (op_q[i] == "W") begin
          do_write(id_q[i], addr_q[i], len_q[i], strb_q[i], resp_q[i]);
          b_want++;
        end else begin
          do_read(id_q[i], addr_q[i], len_q[i], resp_q[i]);
          r_want += int'(len_q[i]) + 1;
        end
      end
      // Room for any stray response to show up
      repeat (20) @(posedge clk_i);
      if (b_seen != b_want || r_seen != r_want) begin
        $display("Error: saw %0d write and %0d read responses, wanted %0d and %0d",
                 b_seen, r_seen, b_want, r_want);
        other_errs++;
      end
    end
    print_counts();
    if (resp_errs + id_errs + data_errs + last_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== test_input.txt ====
# op id addr len strb resp; op is W or R, the other fields are hex
# len is beats minus one; strb is unused on reads; resp is B code or worst R code
W 1 00000008 00 f 0
R 1 00000008 00 f 0
W 2 00000010 03 f 0
R 3 00000010 03 f 0
W 4 00000038 03 f 2
R 5 00000038 03 f 2
W 6 00000008 00 3 0
R 7 00000008 00 f 0
W 8 00000024 00 c 0
R 9 00000020 01 f 0
W a 00000000 07 f 0
R b 00000000 0f f 0
R c 00000030 07 f 2
W d 00000040 01 f 2
R e 00000040 01 f 2
W f 0000003c 00 1 0
R 0 0000003c 00 f 0
W 3 00000004 02 6 0
R 2 00000000 03 f 0

// ==== verilog.f ====
axi_cfg_pkg.sv
axi_types_pkg.sv
axi_beat_if.sv
axi_lite_if.sv
id_fifo.sv
axi_burst_splitter.sv
axi_id_reflect.sv
lite_reg_file.sv
axi_lite_bridge_top.sv
tb_axi_lite_bridge.sv

// ==== Makefile ====
# Verilator flow for the AXI4 to AXI4-Lite bridge
TOP := tb_axi_lite_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module axi_lite_bridge_top

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
